//--- tcls_pkg.sv
// ########################################
// TCLS shared definitions
// Widths, register map and recovery modes
// ########################################

package tcls_pkg;

  // Bus and core side widths
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned BE_W     = 4;
  localparam int unsigned IRQ_ID_W = 5;

  // Main vote: irq ack, irq ack id, instr req, instr addr, data req
  localparam int unsigned MAIN_VOTE_W = 1 + IRQ_ID_W + 1 + ADDR_W + 1;

  // Data vote: data addr, we, wdata, be
  localparam int unsigned DATA_VOTE_W = ADDR_W + 1 + DATA_W + BE_W;

  // Register port word address
  localparam int unsigned REG_ADDR_W = 3;

  // Register word addresses
  typedef enum logic [REG_ADDR_W-1:0] {
    // bit0 setback enable, bit1 reload setback enable
    REG_CONFIG    = 3'd0,
    REG_SP_STORE  = 3'd1,
    // Read-only per-core mismatch counters
    REG_MISMATCH0 = 3'd2,
    REG_MISMATCH1 = 3'd3,
    REG_MISMATCH2 = 3'd4
  } tcls_reg_e;

  // Recovery mode of the lock-step unit
  typedef enum logic [1:0] {
    MODE_RUN,
    MODE_UNLOAD,
    MODE_RELOAD
  } red_mode_e;

endpackage

//--- tcls_voter.sv
// ########################################
// TCLS majority voter
// Bitwise vote over three redundant copies
// ########################################

module tcls_voter #(
  parameter int unsigned Width = 32
) (
  input  logic [Width-1:0] a_i,
  input  logic [Width-1:0] b_i,
  input  logic [Width-1:0] c_i,
  output logic [Width-1:0] majority_o,
  output logic [2:0]       error_cba_o,
  output logic             multi_error_o
);

  logic [Width-1:0] diff_a;
  logic [Width-1:0] diff_b;
  logic [Width-1:0] diff_c;

  // Two out of three per bit
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // Bits where each copy disagrees with the vote
  assign diff_a = a_i ^ majority_o;
  assign diff_b = b_i ^ majority_o;
  assign diff_c = c_i ^ majority_o;

  assign error_cba_o[0] = |diff_a;
  assign error_cba_o[1] = |diff_b;
  assign error_cba_o[2] = |diff_c;

  // Two or more copies wrong, so the result is not trustworthy
  assign multi_error_o = (error_cba_o[0] & error_cba_o[1]) |
                         (error_cba_o[0] & error_cba_o[2]) |
                         (error_cba_o[1] & error_cba_o[2]);

endmodule

//--- tcls_regs.sv
// ########################################
// TCLS register file
// Config, state pointer, mismatch counters
// ########################################

module tcls_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Register port
  input  logic                            reg_req_i,
  input  logic                            reg_we_i,
  input  logic [tcls_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [31:0]                     reg_wdata_i,
  output logic [31:0]                     reg_rdata_o,

  // One pulse per flagged core
  input  logic [2:0]                      mismatch_inc_i,

  output logic                            cfg_setback_o,
  output logic                            cfg_reload_setback_o,
  output logic                            sp_valid_o,
  output logic                            sp_clear_o
);

  logic [1:0]          config_q;
  logic [31:0]         sp_store_q;
  logic [2:0][31:0]    mismatch_q;
  logic                wr_en;
  tcls_pkg::tcls_reg_e reg_addr;

  assign reg_addr = tcls_pkg::tcls_reg_e'(reg_addr_i);
  assign wr_en    = reg_req_i & reg_we_i;

  // Writable registers, counters and unknown words ignore writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      config_q   <= '0;
      sp_store_q <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        tcls_pkg::REG_CONFIG: begin
          config_q <= reg_wdata_i[1:0];
        end
        tcls_pkg::REG_SP_STORE: begin
          sp_store_q <= reg_wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

  // Per-core mismatch counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q <= '0;
    end else begin
      for (int k = 0; k < 3; k++) begin
        if (mismatch_inc_i[k]) begin
          mismatch_q[k] <= mismatch_q[k] + 32'd1;
        end
      end
    end
  end

  // Same-cycle read data
  always_comb begin
    reg_rdata_o = '0;
    if (reg_req_i) begin
      case (reg_addr)
        tcls_pkg::REG_CONFIG:    reg_rdata_o = {30'd0, config_q};
        tcls_pkg::REG_SP_STORE:  reg_rdata_o = sp_store_q;
        tcls_pkg::REG_MISMATCH0: reg_rdata_o = mismatch_q[0];
        tcls_pkg::REG_MISMATCH1: reg_rdata_o = mismatch_q[1];
        tcls_pkg::REG_MISMATCH2: reg_rdata_o = mismatch_q[2];
        default:                 reg_rdata_o = '0;
      endcase
    end
  end

  assign cfg_setback_o        = config_q[0];
  assign cfg_reload_setback_o = config_q[1];

  // A stored state pointer means the cores have saved their state
  assign sp_valid_o = |sp_store_q;

  // Software clearing the pointer in this cycle
  assign sp_clear_o = wr_en && (reg_addr == tcls_pkg::REG_SP_STORE) &&
                      (reg_wdata_i == 32'd0);

endmodule

//--- tcls_unit.sv
// ########################################
// TCLS lock-step unit
// Voting, fan-out and recovery FSM
// ########################################

module tcls_unit (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Register file links
  input  logic                                cfg_setback_i,
  input  logic                                cfg_reload_setback_i,
  input  logic                                sp_valid_i,
  input  logic                                sp_clear_i,
  output logic [2:0]                          mismatch_inc_o,

  // Interconnect side
  input  logic [tcls_pkg::ADDR_W-1:0]         intc_hart_id_i,
  input  logic                                intc_fetch_en_i,
  input  logic [tcls_pkg::ADDR_W-1:0]         intc_boot_addr_i,
  input  logic [31:0]                         intc_irq_x_i,
  output logic                                intc_irq_x_ack_o,
  output logic [tcls_pkg::IRQ_ID_W-1:0]       intc_irq_x_ack_id_o,
  input  logic                                intc_debug_req_i,

  output logic                                intc_instr_req_o,
  output logic [tcls_pkg::ADDR_W-1:0]         intc_instr_addr_o,
  input  logic                                intc_instr_gnt_i,
  input  logic [tcls_pkg::DATA_W-1:0]         intc_instr_rdata_i,
  input  logic                                intc_instr_rvalid_i,
  input  logic                                intc_instr_err_i,

  output logic                                intc_data_req_o,
  output logic [tcls_pkg::ADDR_W-1:0]         intc_data_addr_o,
  output logic                                intc_data_we_o,
  output logic [tcls_pkg::DATA_W-1:0]         intc_data_wdata_o,
  output logic [tcls_pkg::BE_W-1:0]           intc_data_be_o,
  input  logic                                intc_data_gnt_i,
  input  logic [tcls_pkg::DATA_W-1:0]         intc_data_rdata_i,
  input  logic                                intc_data_rvalid_i,
  input  logic                                intc_data_err_i,

  // Core side
  output logic [2:0]                          core_setback_o,
  output logic [2:0][tcls_pkg::ADDR_W-1:0]    core_hart_id_o,
  output logic [2:0]                          core_fetch_en_o,
  output logic [2:0][tcls_pkg::ADDR_W-1:0]    core_boot_addr_o,
  output logic [2:0][31:0]                    core_irq_x_o,
  input  logic [2:0]                          core_irq_x_ack_i,
  input  logic [2:0][tcls_pkg::IRQ_ID_W-1:0]  core_irq_x_ack_id_i,
  output logic [2:0]                          core_debug_req_o,

  input  logic [2:0]                          core_instr_req_i,
  input  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_instr_addr_i,
  output logic [2:0]                          core_instr_gnt_o,
  output logic [2:0][tcls_pkg::DATA_W-1:0]    core_instr_rdata_o,
  output logic [2:0]                          core_instr_rvalid_o,
  output logic [2:0]                          core_instr_err_o,

  input  logic [2:0]                          core_data_req_i,
  input  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_data_addr_i,
  input  logic [2:0]                          core_data_we_i,
  input  logic [2:0][tcls_pkg::DATA_W-1:0]    core_data_wdata_i,
  input  logic [2:0][tcls_pkg::BE_W-1:0]      core_data_be_i,
  output logic [2:0]                          core_data_gnt_o,
  output logic [2:0][tcls_pkg::DATA_W-1:0]    core_data_rdata_o,
  output logic [2:0]                          core_data_rvalid_o,
  output logic [2:0]                          core_data_err_o,

  output logic                                single_mismatch_o,
  output logic                                triple_mismatch_o
);

  logic [2:0][tcls_pkg::MAIN_VOTE_W-1:0] main_in;
  logic [tcls_pkg::MAIN_VOTE_W-1:0]      main_out;
  logic [2:0]                            main_cba;
  logic                                  main_multi;

  logic [2:0][tcls_pkg::DATA_VOTE_W-1:0] data_in;
  logic [tcls_pkg::DATA_VOTE_W-1:0]      data_out;
  logic [2:0]                            data_cba;
  logic                                  data_multi;

  logic                                  data_req;
  logic [2:0]                            err_detect;
  logic                                  any_mismatch;
  logic                                  cross_multi;

  tcls_pkg::red_mode_e                   red_mode_d;
  tcls_pkg::red_mode_e                   red_mode_q;
  logic                                  setback_d;
  logic                                  setback_q;

  for (genvar k = 0; k < 3; k++) begin : gen_pack
    assign main_in[k] = {core_irq_x_ack_i[k], core_irq_x_ack_id_i[k], core_instr_req_i[k],
                         core_instr_addr_i[k], core_data_req_i[k]};
    assign data_in[k] = {core_data_addr_i[k], core_data_we_i[k], core_data_wdata_i[k],
                         core_data_be_i[k]};
  end

  tcls_voter #(
    .Width ( tcls_pkg::MAIN_VOTE_W )
  ) main_voter (
    .a_i           ( main_in[0] ),
    .b_i           ( main_in[1] ),
    .c_i           ( main_in[2] ),
    .majority_o    ( main_out   ),
    .error_cba_o   ( main_cba   ),
    .multi_error_o ( main_multi )
  );

  tcls_voter #(
    .Width ( tcls_pkg::DATA_VOTE_W )
  ) data_voter (
    .a_i           ( data_in[0] ),
    .b_i           ( data_in[1] ),
    .c_i           ( data_in[2] ),
    .majority_o    ( data_out   ),
    .error_cba_o   ( data_cba   ),
    .multi_error_o ( data_multi )
  );

  // Voted copies to the interconnect
  assign {intc_irq_x_ack_o, intc_irq_x_ack_id_o, intc_instr_req_o, intc_instr_addr_o,
          data_req} = main_out;
  assign {intc_data_addr_o, intc_data_we_o, intc_data_wdata_o, intc_data_be_o} = data_out;
  assign intc_data_req_o = data_req;

  // Data payload only matters while a data request is out
  assign err_detect   = main_cba | (data_req ? data_cba : 3'b000);
  assign any_mismatch = |err_detect;

  // Faults split over the two voters also make two bad cores
  assign cross_multi = (err_detect[0] & err_detect[1]) |
                       (err_detect[0] & err_detect[2]) |
                       (err_detect[1] & err_detect[2]);

  assign single_mismatch_o = any_mismatch;
  assign triple_mismatch_o = main_multi | (data_req & data_multi) | cross_multi;

  // Only faults seen in run mode are counted
  assign mismatch_inc_o = (red_mode_q == tcls_pkg::MODE_RUN) ? err_detect : 3'b000;

  always_comb begin
    red_mode_d = red_mode_q;
    setback_d  = 1'b0;
    case (red_mode_q)
      tcls_pkg::MODE_RUN: begin
        if (any_mismatch) begin
          red_mode_d = tcls_pkg::MODE_UNLOAD;
        end
      end
      tcls_pkg::MODE_UNLOAD: begin
        // Cores have stored their state pointer
        if (sp_valid_i) begin
          red_mode_d = tcls_pkg::MODE_RELOAD;
          setback_d  = cfg_setback_i;
        end
      end
      tcls_pkg::MODE_RELOAD: begin
        if (!sp_valid_i) begin
          red_mode_d = tcls_pkg::MODE_RUN;
        end else if (any_mismatch && cfg_setback_i && cfg_reload_setback_i &&
                     !sp_clear_i && !setback_q) begin
          // Cores still diverge while reloading
          setback_d = 1'b1;
        end
      end
      default: begin
        red_mode_d = tcls_pkg::MODE_RUN;
      end
    endcase

    if (!intc_fetch_en_i) begin
      red_mode_d = tcls_pkg::MODE_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      red_mode_q <= tcls_pkg::MODE_RUN;
      setback_q  <= 1'b0;
    end else begin
      red_mode_q <= red_mode_d;
      setback_q  <= setback_d;
    end
  end

  assign core_setback_o = {3{setback_q}};

  // Responses and control inputs go to every core
  assign core_hart_id_o      = {3{intc_hart_id_i}};
  assign core_fetch_en_o     = {3{intc_fetch_en_i}};
  assign core_boot_addr_o    = {3{intc_boot_addr_i}};
  assign core_irq_x_o        = {3{intc_irq_x_i}};
  assign core_debug_req_o    = {3{intc_debug_req_i}};

  assign core_instr_gnt_o    = {3{intc_instr_gnt_i}};
  assign core_instr_rdata_o  = {3{intc_instr_rdata_i}};
  assign core_instr_rvalid_o = {3{intc_instr_rvalid_i}};
  assign core_instr_err_o    = {3{intc_instr_err_i}};

  assign core_data_gnt_o     = {3{intc_data_gnt_i}};
  assign core_data_rdata_o   = {3{intc_data_rdata_i}};
  assign core_data_rvalid_o  = {3{intc_data_rvalid_i}};
  assign core_data_err_o     = {3{intc_data_err_i}};

endmodule

//--- tcls_top.sv
// ########################################
// TCLS top level
// Register file plus lock-step unit
// ########################################

module tcls_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Register port
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  logic [tcls_pkg::REG_ADDR_W-1:0]     reg_addr_i,
  input  logic [31:0]                         reg_wdata_i,
  output logic [31:0]                         reg_rdata_o,

  // Interconnect side
  input  logic [tcls_pkg::ADDR_W-1:0]         intc_hart_id_i,
  input  logic                                intc_fetch_en_i,
  input  logic [tcls_pkg::ADDR_W-1:0]         intc_boot_addr_i,
  input  logic [31:0]                         intc_irq_x_i,
  output logic                                intc_irq_x_ack_o,
  output logic [tcls_pkg::IRQ_ID_W-1:0]       intc_irq_x_ack_id_o,
  input  logic                                intc_debug_req_i,

  output logic                                intc_instr_req_o,
  output logic [tcls_pkg::ADDR_W-1:0]         intc_instr_addr_o,
  input  logic                                intc_instr_gnt_i,
  input  logic [tcls_pkg::DATA_W-1:0]         intc_instr_rdata_i,
  input  logic                                intc_instr_rvalid_i,
  input  logic                                intc_instr_err_i,

  output logic                                intc_data_req_o,
  output logic [tcls_pkg::ADDR_W-1:0]         intc_data_addr_o,
  output logic                                intc_data_we_o,
  output logic [tcls_pkg::DATA_W-1:0]         intc_data_wdata_o,
  output logic [tcls_pkg::BE_W-1:0]           intc_data_be_o,
  input  logic                                intc_data_gnt_i,
  input  logic [tcls_pkg::DATA_W-1:0]         intc_data_rdata_i,
  input  logic                                intc_data_rvalid_i,
  input  logic                                intc_data_err_i,

  // Core side
  output logic [2:0]                          core_setback_o,
  output logic [2:0][tcls_pkg::ADDR_W-1:0]    core_hart_id_o,
  output logic [2:0]                          core_fetch_en_o,
  output logic [2:0][tcls_pkg::ADDR_W-1:0]    core_boot_addr_o,
  output logic [2:0][31:0]                    core_irq_x_o,
  input  logic [2:0]                          core_irq_x_ack_i,
  input  logic [2:0][tcls_pkg::IRQ_ID_W-1:0]  core_irq_x_ack_id_i,
  output logic [2:0]                          core_debug_req_o,

  input  logic [2:0]                          core_instr_req_i,
  input  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_instr_addr_i,
  output logic [2:0]                          core_instr_gnt_o,
  output logic [2:0][tcls_pkg::DATA_W-1:0]    core_instr_rdata_o,
  output logic [2:0]                          core_instr_rvalid_o,
  output logic [2:0]                          core_instr_err_o,

  input  logic [2:0]                          core_data_req_i,
  input  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_data_addr_i,
  input  logic [2:0]                          core_data_we_i,
  input  logic [2:0][tcls_pkg::DATA_W-1:0]    core_data_wdata_i,
  input  logic [2:0][tcls_pkg::BE_W-1:0]      core_data_be_i,
  output logic [2:0]                          core_data_gnt_o,
  output logic [2:0][tcls_pkg::DATA_W-1:0]    core_data_rdata_o,
  output logic [2:0]                          core_data_rvalid_o,
  output logic [2:0]                          core_data_err_o,

  output logic                                single_mismatch_o,
  output logic                                triple_mismatch_o
);

  logic       cfg_setback;
  logic       cfg_reload_setback;
  logic       sp_valid;
  logic       sp_clear;
  logic [2:0] mismatch_inc;

  tcls_regs i_regs (
    .clk_i                ( clk_i              ),
    .rst_ni               ( rst_ni             ),
    .reg_req_i            ( reg_req_i          ),
    .reg_we_i             ( reg_we_i           ),
    .reg_addr_i           ( reg_addr_i         ),
    .reg_wdata_i          ( reg_wdata_i        ),
    .reg_rdata_o          ( reg_rdata_o        ),
    .mismatch_inc_i       ( mismatch_inc       ),
    .cfg_setback_o        ( cfg_setback        ),
    .cfg_reload_setback_o ( cfg_reload_setback ),
    .sp_valid_o           ( sp_valid           ),
    .sp_clear_o           ( sp_clear           )
  );

  // Bus and core ports share their names with the unit
  tcls_unit i_unit (
    .cfg_setback_i        ( cfg_setback        ),
    .cfg_reload_setback_i ( cfg_reload_setback ),
    .sp_valid_i           ( sp_valid           ),
    .sp_clear_i           ( sp_clear           ),
    .mismatch_inc_o       ( mismatch_inc       ),
    .*
  );

endmodule

//--- tcls_assert.sv
// ########################################
// TCLS unit assertions
// Setback pulse shape and mismatch flags
// ########################################

module tcls_assert (
  input logic       clk_i,
  input logic       rst_ni,
  input logic [2:0] setback_i,
  input logic       single_mismatch_i,
  input logic       triple_mismatch_i
);

  int unsigned fail_count = 0;

  // Setback is a single-cycle pulse
  setback_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (setback_i != 3'b000) |=> (setback_i == 3'b000)
  ) else begin
    fail_count++;
    $error("setback high on two consecutive cycles");
  end

  // All cores are set back together
  setback_all_cores: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (setback_i == 3'b000) || (setback_i == 3'b111)
  ) else begin
    fail_count++;
    $error("setback bits differ between cores");
  end

  // An uncorrectable fault is always also a mismatch
  triple_has_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    triple_mismatch_i |-> single_mismatch_i
  ) else begin
    fail_count++;
    $error("triple mismatch without single mismatch");
  end

endmodule

//--- tb_tcls_top.sv
// ########################################
// TCLS testbench
// Three core models and directed tests
// ########################################

module tb_tcls_top;

  logic                                clk_i;
  logic                                rst_ni;

  logic                                reg_req_i;
  logic                                reg_we_i;
  logic [tcls_pkg::REG_ADDR_W-1:0]     reg_addr_i;
  logic [31:0]                         reg_wdata_i;
  logic [31:0]                         reg_rdata_o;

  logic [tcls_pkg::ADDR_W-1:0]         intc_hart_id_i;
  logic                                intc_fetch_en_i;
  logic [tcls_pkg::ADDR_W-1:0]         intc_boot_addr_i;
  logic [31:0]                         intc_irq_x_i;
  logic                                intc_irq_x_ack_o;
  logic [tcls_pkg::IRQ_ID_W-1:0]       intc_irq_x_ack_id_o;
  logic                                intc_debug_req_i;
  logic                                intc_instr_req_o;
  logic [tcls_pkg::ADDR_W-1:0]         intc_instr_addr_o;
  logic                                intc_instr_gnt_i;
  logic [tcls_pkg::DATA_W-1:0]         intc_instr_rdata_i;
  logic                                intc_instr_rvalid_i;
  logic                                intc_instr_err_i;
  logic                                intc_data_req_o;
  logic [tcls_pkg::ADDR_W-1:0]         intc_data_addr_o;
  logic                                intc_data_we_o;
  logic [tcls_pkg::DATA_W-1:0]         intc_data_wdata_o;
  logic [tcls_pkg::BE_W-1:0]           intc_data_be_o;
  logic                                intc_data_gnt_i;
  logic [tcls_pkg::DATA_W-1:0]         intc_data_rdata_i;
  logic                                intc_data_rvalid_i;
  logic                                intc_data_err_i;

  logic [2:0]                          core_setback_o;
  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_hart_id_o;
  logic [2:0]                          core_fetch_en_o;
  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_boot_addr_o;
  logic [2:0][31:0]                    core_irq_x_o;
  logic [2:0]                          core_irq_x_ack_i;
  logic [2:0][tcls_pkg::IRQ_ID_W-1:0]  core_irq_x_ack_id_i;
  logic [2:0]                          core_debug_req_o;
  logic [2:0]                          core_instr_req_i;
  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_instr_addr_i;
  logic [2:0]                          core_instr_gnt_o;
  logic [2:0][tcls_pkg::DATA_W-1:0]    core_instr_rdata_o;
  logic [2:0]                          core_instr_rvalid_o;
  logic [2:0]                          core_instr_err_o;
  logic [2:0]                          core_data_req_i;
  logic [2:0][tcls_pkg::ADDR_W-1:0]    core_data_addr_i;
  logic [2:0]                          core_data_we_i;
  logic [2:0][tcls_pkg::DATA_W-1:0]    core_data_wdata_i;
  logic [2:0][tcls_pkg::BE_W-1:0]      core_data_be_i;
  logic [2:0]                          core_data_gnt_o;
  logic [2:0][tcls_pkg::DATA_W-1:0]    core_data_rdata_o;
  logic [2:0]                          core_data_rvalid_o;
  logic [2:0]                          core_data_err_o;

  logic                                single_mismatch_o;
  logic                                triple_mismatch_o;

  // Common core output values for all three core models
  logic                                gold_irq_ack;
  logic [tcls_pkg::IRQ_ID_W-1:0]       gold_irq_id;
  logic                                gold_instr_req;
  logic [tcls_pkg::ADDR_W-1:0]         gold_instr_addr;
  logic                                gold_data_req;
  logic [tcls_pkg::ADDR_W-1:0]         gold_data_addr;
  logic                                gold_data_we;
  logic [tcls_pkg::DATA_W-1:0]         gold_data_wdata;
  logic [tcls_pkg::BE_W-1:0]           gold_data_be;

  integer                              seed;
  int unsigned                         exp_cnt [3];
  int unsigned                         pulse_cnt = 0;

  tcls_top UUT (.*);

  bind tcls_unit tcls_assert u_assert (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .setback_i         ( core_setback_o    ),
    .single_mismatch_i ( single_mismatch_o ),
    .triple_mismatch_i ( triple_mismatch_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Count setback pulses at the stable falling edge
  always @(negedge clk_i) begin
    if (rst_ni && (core_setback_o != 3'b000)) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] actual,
                          input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
    reg_req_i   = 1'b1;
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
  endtask

  task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
    reg_req_i  = 1'b1;
    reg_we_i   = 1'b0;
    reg_addr_i = addr;
    #1;
    data = reg_rdata_o;
    @(negedge clk_i);
    reg_req_i = 1'b0;
  endtask

  task automatic check_counters();
    logic [31:0] val;
    for (int k = 0; k < 3; k++) begin
      reg_read(3'(int'(tcls_pkg::REG_MISMATCH0) + k), val);
      check_eq($sformatf("mismatch counter %0d", k), 64'(val), 64'(exp_cnt[k]));
    end
  endtask

  task automatic drive_cores();
    for (int k = 0; k < 3; k++) begin
      core_irq_x_ack_i[k]    = gold_irq_ack;
      core_irq_x_ack_id_i[k] = gold_irq_id;
      core_instr_req_i[k]    = gold_instr_req;
      core_instr_addr_i[k]   = gold_instr_addr;
      core_data_req_i[k]     = gold_data_req;
      core_data_addr_i[k]    = gold_data_addr;
      core_data_we_i[k]      = gold_data_we;
      core_data_wdata_i[k]   = gold_data_wdata;
      core_data_be_i[k]      = gold_data_be;
    end
  endtask

  task automatic new_core_values(input logic data_req);
    gold_irq_ack    = 1'($random(seed));
    gold_irq_id     = 5'($random(seed));
    gold_instr_req  = 1'($random(seed));
    gold_instr_addr = 32'($random(seed));
    gold_data_req   = data_req;
    gold_data_addr  = 32'($random(seed));
    gold_data_we    = 1'($random(seed));
    gold_data_wdata = 32'($random(seed));
    gold_data_be    = 4'($random(seed));
    drive_cores();
  endtask

  task automatic randomize_intc();
    intc_hart_id_i      = 32'($random(seed));
    intc_boot_addr_i    = 32'($random(seed));
    intc_irq_x_i        = 32'($random(seed));
    intc_debug_req_i    = 1'($random(seed));
    intc_instr_gnt_i    = 1'($random(seed));
    intc_instr_rdata_i  = 32'($random(seed));
    intc_instr_rvalid_i = 1'($random(seed));
    intc_instr_err_i    = 1'($random(seed));
    intc_data_gnt_i     = 1'($random(seed));
    intc_data_rdata_i   = 32'($random(seed));
    intc_data_rvalid_i  = 1'($random(seed));
    intc_data_err_i     = 1'($random(seed));
  endtask

  task automatic check_flags(input logic single, input logic triple);
    check_eq("single_mismatch_o", 64'(single_mismatch_o), 64'(single));
    check_eq("triple_mismatch_o", 64'(triple_mismatch_o), 64'(triple));
  endtask

  // Flip one instr addr bit of a core across one rising edge
  task automatic instr_fault(input int core, input int bit_idx);
    new_core_values(1'b0);
    core_instr_addr_i[core][bit_idx] = ~core_instr_addr_i[core][bit_idx];
    #1;
    check_eq("intc_instr_addr_o", 64'(intc_instr_addr_o), 64'(gold_instr_addr));
    check_flags(1'b1, 1'b0);
    @(negedge clk_i);
    drive_cores();
  endtask

  // Store then clear the state pointer to walk through UNLOAD and RELOAD back to RUN
  task automatic recover_via_sp();
    reg_write(tcls_pkg::REG_SP_STORE, 32'($random(seed)) | 32'd1);
    reg_write(tcls_pkg::REG_SP_STORE, 32'd0);
    @(negedge clk_i);
  endtask

  task automatic wait_setback(input int max_cycles);
    int n;
    n = 0;
    while (core_setback_o == 3'b000) begin
      if (n == max_cycles) begin
        abort_run("Timed out waiting for the setback pulse to the cores");
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic test_agreement();
    for (int n = 0; n < 4; n++) begin
      new_core_values((n % 2) == 1);
      randomize_intc();
      #1;
      check_eq("intc_irq_x_ack_o", 64'(intc_irq_x_ack_o), 64'(gold_irq_ack));
      check_eq("intc_irq_x_ack_id_o", 64'(intc_irq_x_ack_id_o), 64'(gold_irq_id));
      check_eq("intc_instr_req_o", 64'(intc_instr_req_o), 64'(gold_instr_req));
      check_eq("intc_instr_addr_o", 64'(intc_instr_addr_o), 64'(gold_instr_addr));
      check_eq("intc_data_req_o", 64'(intc_data_req_o), 64'(gold_data_req));
      check_eq("intc_data_addr_o", 64'(intc_data_addr_o), 64'(gold_data_addr));
      check_eq("intc_data_we_o", 64'(intc_data_we_o), 64'(gold_data_we));
      check_eq("intc_data_wdata_o", 64'(intc_data_wdata_o), 64'(gold_data_wdata));
      check_eq("intc_data_be_o", 64'(intc_data_be_o), 64'(gold_data_be));
      check_flags(1'b0, 1'b0);
      for (int k = 0; k < 3; k++) begin
        check_eq("core_hart_id_o", 64'(core_hart_id_o[k]), 64'(intc_hart_id_i));
        check_eq("core_fetch_en_o", 64'(core_fetch_en_o[k]), 64'(intc_fetch_en_i));
        check_eq("core_boot_addr_o", 64'(core_boot_addr_o[k]), 64'(intc_boot_addr_i));
        check_eq("core_irq_x_o", 64'(core_irq_x_o[k]), 64'(intc_irq_x_i));
        check_eq("core_debug_req_o", 64'(core_debug_req_o[k]), 64'(intc_debug_req_i));
        check_eq("core_instr_gnt_o", 64'(core_instr_gnt_o[k]), 64'(intc_instr_gnt_i));
        check_eq("core_instr_rdata_o", 64'(core_instr_rdata_o[k]), 64'(intc_instr_rdata_i));
        check_eq("core_instr_rvalid_o", 64'(core_instr_rvalid_o[k]), 64'(intc_instr_rvalid_i));
        check_eq("core_instr_err_o", 64'(core_instr_err_o[k]), 64'(intc_instr_err_i));
        check_eq("core_data_gnt_o", 64'(core_data_gnt_o[k]), 64'(intc_data_gnt_i));
        check_eq("core_data_rdata_o", 64'(core_data_rdata_o[k]), 64'(intc_data_rdata_i));
        check_eq("core_data_rvalid_o", 64'(core_data_rvalid_o[k]), 64'(intc_data_rvalid_i));
        check_eq("core_data_err_o", 64'(core_data_err_o[k]), 64'(intc_data_err_i));
      end
      @(negedge clk_i);
    end
    check_counters();
  endtask

  task automatic test_single_fault();
    for (int k = 0; k < 3; k++) begin
      instr_fault(k, int'(5'($random(seed))));
      exp_cnt[k]++;
      check_counters();
      // Mode has left RUN, so this fault is not counted
      instr_fault(k, int'(5'($random(seed))));
      check_counters();
      recover_via_sp();
    end
  endtask

  task automatic test_recovery();
    int unsigned pulses;
    logic [31:0] val;
    reg_write(tcls_pkg::REG_CONFIG, 32'h1);
    reg_read(tcls_pkg::REG_CONFIG, val);
    check_eq("CONFIG", 64'(val), 64'h1);
    pulses = pulse_cnt;
    instr_fault(1, 3);
    exp_cnt[1]++;
    reg_write(tcls_pkg::REG_SP_STORE, 32'h0000_1000);
    wait_setback(4);
    check_eq("core_setback_o", 64'(core_setback_o), 64'h7);
    @(negedge clk_i);
    check_eq("core_setback_o", 64'(core_setback_o), 64'h0);
    reg_write(tcls_pkg::REG_SP_STORE, 32'd0);
    @(negedge clk_i);
    check_eq("setback pulse count", 64'(pulse_cnt - pulses), 64'd1);
    // Back in RUN, so a new fault counts again
    instr_fault(1, 9);
    exp_cnt[1]++;
    check_counters();
    reg_write(tcls_pkg::REG_CONFIG, 32'h0);
    pulses = pulse_cnt;
    recover_via_sp();
    @(negedge clk_i);
    check_eq("setback pulse count", 64'(pulse_cnt - pulses), 64'd0);
  endtask

  task automatic test_data_gating();
    new_core_values(1'b0);
    core_data_wdata_i[2][5] = ~core_data_wdata_i[2][5];
    #1;
    check_flags(1'b0, 1'b0);
    @(negedge clk_i);
    check_counters();
    for (int k = 0; k < 3; k++) begin
      core_data_req_i[k] = 1'b1;
    end
    #1;
    check_flags(1'b1, 1'b0);
    check_eq("intc_data_wdata_o", 64'(intc_data_wdata_o), 64'(gold_data_wdata));
    @(negedge clk_i);
    drive_cores();
    exp_cnt[2]++;
    check_counters();
    recover_via_sp();
  endtask

  task automatic test_uncorrectable();
    new_core_values(1'b0);
    core_instr_addr_i[0][0] = ~core_instr_addr_i[0][0];
    core_instr_addr_i[1][1] = ~core_instr_addr_i[1][1];
    #1;
    check_flags(1'b1, 1'b1);
    check_eq("intc_instr_addr_o", 64'(intc_instr_addr_o), 64'(gold_instr_addr));
    @(negedge clk_i);
    drive_cores();
    exp_cnt[0]++;
    exp_cnt[1]++;
    check_counters();
    recover_via_sp();
  endtask

  task automatic test_fetch_en_reset();
    instr_fault(0, 17);
    exp_cnt[0]++;
    intc_fetch_en_i = 1'b0;
    #1;
    check_eq("core_fetch_en_o", 64'(core_fetch_en_o), 64'h0);
    @(negedge clk_i);
    intc_fetch_en_i = 1'b1;
    instr_fault(0, 23);
    exp_cnt[0]++;
    check_counters();
  endtask

  initial begin
    seed        = 10798;
    exp_cnt     = '{0, 0, 0};
    rst_ni      = 1'b0;
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    intc_fetch_en_i = 1'b1;
    randomize_intc();
    new_core_values(1'b0);
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    test_agreement();
    test_single_fault();
    test_recovery();
    test_data_gating();
    test_uncorrectable();
    test_fetch_en_reset();

    if (UUT.i_unit.u_assert.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
tcls_pkg.sv
tcls_voter.sv
tcls_regs.sv
tcls_unit.sv
tcls_top.sv
tcls_assert.sv
tb_tcls_top.sv

//--- Makefile
# Verilator flow for the TCLS subsystem

TB := tb_tcls_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module tcls_top

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TB)
	@out="$$(./obj_dir/V$(TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
